//--- design/sobel_pkg.sv
package sobel_pkg;

    //////////////////////////////////////////////////
    // Pixel and datapath types
    //////////////////////////////////////////////////

    // RGB444, red in the top nibble
    typedef logic [11:0] rgb_t;

    typedef logic [3:0] luma_t;

    // Signed, -60 to 60 for a 4-bit luma
    typedef logic signed [7:0] grad_t;

    // Gx squared plus Gy squared, at most 7200
    typedef logic [12:0] mag_t;

    typedef logic [3:0] margin_t;

    //////////////////////////////////////////////////
    // APB register map
    //////////////////////////////////////////////////

    typedef logic [7:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Bit 0 start, write one to pulse
    localparam apb_addr_t REG_CTRL       = 8'h00;
    localparam apb_addr_t REG_THRESH     = 8'h04;
    localparam apb_addr_t REG_MARGIN     = 8'h08;
    // Bit 0 busy, bit 1 done
    localparam apb_addr_t REG_STATUS     = 8'h0C;
    localparam apb_addr_t REG_EDGE_COUNT = 8'h10;

    localparam mag_t THRESH_RESET = 13'd3000;

endpackage

//--- design/sobel_apb_regs.sv
`timescale 1ns/1ps

module sobel_apb_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  sobel_pkg::apb_addr_t paddr,
    input  sobel_pkg::apb_data_t pwdata,
    output sobel_pkg::apb_data_t prdata,
    output logic                 pready,
    output logic                 pslverr,
    input  logic                 frame_done,
    input  logic [31:0]          edge_count,
    output logic                 frame_start,
    output sobel_pkg::mag_t      threshold,
    output sobel_pkg::margin_t   margin
);

    import sobel_pkg::*;

    logic        busy;
    logic        done;
    logic [31:0] last_count;
    logic        access;
    logic        mapped;
    logic        cfg_addr;
    logic        wr_ok;
    logic        start_req;

    //////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////

    assign access   = psel && penable;
    assign pready   = 1'b1;
    assign mapped   = paddr inside {REG_CTRL, REG_THRESH, REG_MARGIN,
                                    REG_STATUS, REG_EDGE_COUNT};
    assign cfg_addr = paddr inside {REG_CTRL, REG_THRESH, REG_MARGIN};

    // Config writes are refused for the whole frame
    assign pslverr = access && (!mapped || (pwrite && busy && cfg_addr));

    assign wr_ok     = access && pwrite && !pslverr;
    assign start_req = wr_ok && (paddr == REG_CTRL) && pwdata[0];

    always_comb begin
        prdata = '0;
        case (paddr)
            REG_THRESH:     prdata = apb_data_t'(threshold);
            REG_MARGIN:     prdata = apb_data_t'(margin);
            REG_STATUS:     prdata = {30'd0, done, busy};
            REG_EDGE_COUNT: prdata = last_count;
            default:        prdata = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Configuration
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            threshold <= THRESH_RESET;
            margin    <= '0;
        end else if (wr_ok) begin
            if (paddr == REG_THRESH) begin
                threshold <= pwdata[$bits(mag_t)-1:0];
            end
            if (paddr == REG_MARGIN) begin
                margin <= pwdata[$bits(margin_t)-1:0];
            end
        end
    end

    //////////////////////////////////////////////////
    // Frame control and status
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_start <= 1'b0;
            busy        <= 1'b0;
            done        <= 1'b0;
            last_count  <= '0;
        end else begin
            frame_start <= start_req;
            if (start_req) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (frame_done) begin
                busy       <= 1'b0;
                done       <= 1'b1;
                last_count <= edge_count;
            end
        end
    end

endmodule

//--- design/sobel_window_fetch.sv
`timescale 1ns/1ps

module sobel_window_fetch #(
    parameter int IMG_WIDTH  = 640,
    parameter int IMG_HEIGHT = 480,
    parameter int ADDR_W     = 19
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              frame_start,
    output logic              src_rd_en,
    output logic [ADDR_W-1:0] src_addr,
    input  sobel_pkg::rgb_t   src_data,
    output logic              win_valid,
    output sobel_pkg::luma_t  w0,
    output sobel_pkg::luma_t  w1,
    output sobel_pkg::luma_t  w2,
    output sobel_pkg::luma_t  w3,
    output sobel_pkg::luma_t  w4,
    output sobel_pkg::luma_t  w5,
    output sobel_pkg::luma_t  w6,
    output sobel_pkg::luma_t  w7,
    output sobel_pkg::luma_t  w8,
    output logic [15:0]       win_x,
    output logic [15:0]       win_y
);

    import sobel_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        DRAIN
    } fetch_state_e;

    localparam logic [ADDR_W-1:0] ROW    = ADDR_W'(IMG_WIDTH);
    localparam logic [ADDR_W-1:0] ONE    = ADDR_W'(1);
    localparam logic [15:0]       X_LAST = 16'(IMG_WIDTH - 2);
    localparam logic [15:0]       Y_LAST = 16'(IMG_HEIGHT - 2);

    fetch_state_e      state;
    logic [3:0]        tap;
    logic [15:0]       cx;
    logic [15:0]       cy;
    logic [ADDR_W-1:0] ctr_addr;
    logic              rd_vld;
    logic [3:0]        rd_tap;
    logic [15:0]       rd_x;
    logic [15:0]       rd_y;
    luma_t             luma;
    luma_t             win [0:8];

    //////////////////////////////////////////////////
    // Centre scan
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            tap      <= '0;
            cx       <= '0;
            cy       <= '0;
            ctr_addr <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (frame_start) begin
                        state    <= READ;
                        tap      <= '0;
                        cx       <= 16'd1;
                        cy       <= 16'd1;
                        ctr_addr <= ROW + ONE;
                    end
                end
                READ: begin
                    if (tap == 4'd8) begin
                        tap <= '0;
                        if (cx == X_LAST) begin
                            // Skip the right and left border pixels
                            cx       <= 16'd1;
                            cy       <= cy + 16'd1;
                            ctr_addr <= ctr_addr + ADDR_W'(3);
                            if (cy == Y_LAST) begin
                                state <= DRAIN;
                            end
                        end else begin
                            cx       <= cx + 16'd1;
                            ctr_addr <= ctr_addr + ONE;
                        end
                    end else begin
                        tap <= tap + 4'd1;
                    end
                end
                DRAIN: begin
                    if (rd_vld && rd_tap == 4'd8) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign src_rd_en = (state == READ);

    // Row-major tap order around the centre
    always_comb begin
        case (tap)
            4'd0:    src_addr = ctr_addr - ROW - ONE;
            4'd1:    src_addr = ctr_addr - ROW;
            4'd2:    src_addr = ctr_addr - ROW + ONE;
            4'd3:    src_addr = ctr_addr - ONE;
            4'd4:    src_addr = ctr_addr;
            4'd5:    src_addr = ctr_addr + ONE;
            4'd6:    src_addr = ctr_addr + ROW - ONE;
            4'd7:    src_addr = ctr_addr + ROW;
            default: src_addr = ctr_addr + ROW + ONE;
        endcase
    end

    //////////////////////////////////////////////////
    // Returning pixels
    //////////////////////////////////////////////////

    assign luma = (src_data[11:8] >> 2) + (src_data[7:4] >> 1)
                + (src_data[7:4] >> 3) + (src_data[3:0] >> 3);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_vld    <= 1'b0;
            rd_tap    <= '0;
            win_valid <= 1'b0;
        end else begin
            rd_vld    <= src_rd_en;
            win_valid <= rd_vld && (rd_tap == 4'd8);
            if (src_rd_en) begin
                rd_tap <= tap;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (src_rd_en) begin
            rd_x <= cx;
            rd_y <= cy;
        end
        if (rd_vld) begin
            win[rd_tap] <= luma;
            if (rd_tap == 4'd8) begin
                win_x <= rd_x;
                win_y <= rd_y;
            end
        end
    end

    assign w0 = win[0];
    assign w1 = win[1];
    assign w2 = win[2];
    assign w3 = win[3];
    assign w4 = win[4];
    assign w5 = win[5];
    assign w6 = win[6];
    assign w7 = win[7];
    assign w8 = win[8];

endmodule

//--- design/sobel_gradient.sv
`timescale 1ns/1ps

module sobel_gradient (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             win_valid,
    input  sobel_pkg::luma_t w0,
    input  sobel_pkg::luma_t w1,
    input  sobel_pkg::luma_t w2,
    input  sobel_pkg::luma_t w3,
    input  sobel_pkg::luma_t w4,
    input  sobel_pkg::luma_t w5,
    input  sobel_pkg::luma_t w6,
    input  sobel_pkg::luma_t w7,
    input  sobel_pkg::luma_t w8,
    input  logic [15:0]      win_x,
    input  logic [15:0]      win_y,
    output logic             mag_valid,
    output sobel_pkg::mag_t  mag,
    output logic [15:0]      mag_x,
    output logic [15:0]      mag_y
);

    import sobel_pkg::*;

    logic [7:0]         left;
    logic [7:0]         right;
    logic [7:0]         top;
    logic [7:0]         bottom;
    grad_t              gx;
    grad_t              gy;
    logic               grad_valid;
    logic [15:0]        grad_x;
    logic [15:0]        grad_y;
    logic signed [15:0] gx_sq;
    logic signed [15:0] gy_sq;

    // Weighted column and row sums, 1 2 1
    // The centre pixel w4 carries no weight in either kernel
    always_comb begin
        left   = {4'd0, w0} + {3'd0, w3, 1'b0} + {4'd0, w6};
        right  = {4'd0, w2} + {3'd0, w5, 1'b0} + {4'd0, w8};
        top    = {4'd0, w0} + {3'd0, w1, 1'b0} + {4'd0, w2};
        bottom = {4'd0, w6} + {3'd0, w7, 1'b0} + {4'd0, w8};
    end

    assign gx_sq = gx * gx;
    assign gy_sq = gy * gy;

    //////////////////////////////////////////////////
    // Valid pipe
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grad_valid <= 1'b0;
            mag_valid  <= 1'b0;
        end else begin
            grad_valid <= win_valid;
            mag_valid  <= grad_valid;
        end
    end

    // Stage 1 gradients, stage 2 sum of squares
    always_ff @(posedge clk) begin
        gx     <= grad_t'(left - right);
        gy     <= grad_t'(top - bottom);
        grad_x <= win_x;
        grad_y <= win_y;
        mag    <= gx_sq[12:0] + gy_sq[12:0];
        mag_x  <= grad_x;
        mag_y  <= grad_y;
    end

endmodule

//--- design/sobel_edge_writer.sv
`timescale 1ns/1ps

module sobel_edge_writer #(
    parameter int IMG_WIDTH  = 640,
    parameter int IMG_HEIGHT = 480,
    parameter int ADDR_W     = 19
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               frame_start,
    input  logic               mag_valid,
    input  sobel_pkg::mag_t    mag,
    input  logic [15:0]        mag_x,
    input  logic [15:0]        mag_y,
    input  sobel_pkg::mag_t    threshold,
    input  sobel_pkg::margin_t margin,
    output logic               edge_we,
    output logic [ADDR_W-1:0]  edge_addr,
    output logic               edge_bit,
    output logic               frame_done,
    output logic [31:0]        edge_count
);

    import sobel_pkg::*;

    localparam logic [15:0] X_MAX  = 16'(IMG_WIDTH - 1);
    localparam logic [15:0] Y_MAX  = 16'(IMG_HEIGHT - 1);
    localparam logic [15:0] X_LAST = 16'(IMG_WIDTH - 2);
    localparam logic [15:0] Y_LAST = 16'(IMG_HEIGHT - 2);

    logic [15:0] m16;
    logic [15:0] x_hi;
    logic [15:0] y_hi;
    logic        in_margin;
    logic        is_edge;
    logic        is_last;
    logic        last_wr;

    //////////////////////////////////////////////////
    // Threshold and border mask
    //////////////////////////////////////////////////

    assign m16  = {12'd0, margin};
    assign x_hi = X_MAX - m16;
    assign y_hi = Y_MAX - m16;

    assign in_margin = (mag_x < m16) || (mag_x > x_hi)
                    || (mag_y < m16) || (mag_y > y_hi);
    assign is_edge   = (mag > threshold) && !in_margin;
    assign is_last   = (mag_x == X_LAST) && (mag_y == Y_LAST);

    always_ff @(posedge clk) begin
        if (mag_valid) begin
            edge_addr <= ADDR_W'(mag_y * IMG_WIDTH + mag_x);
            edge_bit  <= is_edge;
        end
    end

    //////////////////////////////////////////////////
    // Write strobe, count, end of frame
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            edge_we    <= 1'b0;
            last_wr    <= 1'b0;
            frame_done <= 1'b0;
            edge_count <= '0;
        end else begin
            edge_we    <= mag_valid;
            last_wr    <= mag_valid && is_last;
            // One cycle after the last write
            frame_done <= last_wr;
            if (frame_start) begin
                edge_count <= '0;
            end else if (edge_we && edge_bit) begin
                edge_count <= edge_count + 32'd1;
            end
        end
    end

endmodule

//--- design/sobel_top.sv
`timescale 1ns/1ps

module sobel_top #(
    parameter int IMG_WIDTH  = 640,
    parameter int IMG_HEIGHT = 480,
    parameter int ADDR_W     = 19
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  sobel_pkg::apb_addr_t paddr,
    input  sobel_pkg::apb_data_t pwdata,
    output sobel_pkg::apb_data_t prdata,
    output logic                 pready,
    output logic                 pslverr,
    output logic                 src_rd_en,
    output logic [ADDR_W-1:0]    src_addr,
    input  sobel_pkg::rgb_t      src_data,
    output logic                 edge_we,
    output logic [ADDR_W-1:0]    edge_addr,
    output logic                 edge_bit
);

    import sobel_pkg::*;

    logic        frame_start;
    logic        frame_done;
    logic [31:0] edge_count;
    mag_t        threshold;
    margin_t     margin;
    logic        win_valid;
    luma_t       w0, w1, w2, w3, w4, w5, w6, w7, w8;
    logic [15:0] win_x;
    logic [15:0] win_y;
    logic        mag_valid;
    mag_t        mag;
    logic [15:0] mag_x;
    logic [15:0] mag_y;

    //////////////////////////////////////////////////
    // Register block
    //////////////////////////////////////////////////

    sobel_apb_regs u_apb_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .frame_done  (frame_done),
        .edge_count  (edge_count),
        .frame_start (frame_start),
        .threshold   (threshold),
        .margin      (margin)
    );

    //////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////

    sobel_window_fetch #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT),
        .ADDR_W     (ADDR_W)
    ) u_window_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .src_rd_en   (src_rd_en),
        .src_addr    (src_addr),
        .src_data    (src_data),
        .win_valid   (win_valid),
        .w0          (w0),
        .w1          (w1),
        .w2          (w2),
        .w3          (w3),
        .w4          (w4),
        .w5          (w5),
        .w6          (w6),
        .w7          (w7),
        .w8          (w8),
        .win_x       (win_x),
        .win_y       (win_y)
    );

    sobel_gradient u_gradient (
        .clk       (clk),
        .rst_n     (rst_n),
        .win_valid (win_valid),
        .w0        (w0),
        .w1        (w1),
        .w2        (w2),
        .w3        (w3),
        .w4        (w4),
        .w5        (w5),
        .w6        (w6),
        .w7        (w7),
        .w8        (w8),
        .win_x     (win_x),
        .win_y     (win_y),
        .mag_valid (mag_valid),
        .mag       (mag),
        .mag_x     (mag_x),
        .mag_y     (mag_y)
    );

    sobel_edge_writer #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT),
        .ADDR_W     (ADDR_W)
    ) u_edge_writer (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .mag_valid   (mag_valid),
        .mag         (mag),
        .mag_x       (mag_x),
        .mag_y       (mag_y),
        .threshold   (threshold),
        .margin      (margin),
        .edge_we     (edge_we),
        .edge_addr   (edge_addr),
        .edge_bit    (edge_bit),
        .frame_done  (frame_done),
        .edge_count  (edge_count)
    );

endmodule

//--- dv/sobel_sva.sv
`timescale 1ns/1ps

module sobel_sva #(
    parameter int IMG_WIDTH  = 640,
    parameter int IMG_HEIGHT = 480,
    parameter int ADDR_W     = 19
) (
    input logic              clk,
    input logic              rst_n,
    input logic              psel,
    input logic              penable,
    input logic              pready,
    input logic              frame_start,
    input logic              busy,
    input logic              src_rd_en,
    input logic              edge_we,
    input logic [ADDR_W-1:0] edge_addr
);

    localparam int PIXELS = IMG_WIDTH * IMG_HEIGHT;

    int fail_count = 0;

    //////////////////////////////////////////////////
    // APB and memory ports
    //////////////////////////////////////////////////

    a_pready: assert property (@(posedge clk) disable iff (!rst_n)
        psel && penable |-> pready)
        else begin
            fail_count++;
            $error("pready low in an APB access phase");
        end

    a_write_busy: assert property (@(posedge clk) disable iff (!rst_n)
        edge_we |-> busy)
        else begin
            fail_count++;
            $error("edge write while not busy");
        end

    a_edge_range: assert property (@(posedge clk) disable iff (!rst_n)
        edge_we |-> (int'(edge_addr) < PIXELS))
        else begin
            fail_count++;
            $error("edge address outside the frame");
        end

    // Scan only starts from a frame start
    a_fetch_start: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(src_rd_en) |-> $past(frame_start))
        else begin
            fail_count++;
            $error("source read without frame start");
        end

endmodule

bind sobel_top sobel_sva #(
    .IMG_WIDTH  (IMG_WIDTH),
    .IMG_HEIGHT (IMG_HEIGHT),
    .ADDR_W     (ADDR_W)
) u_sva (
    .clk         (clk),
    .rst_n       (rst_n),
    .psel        (psel),
    .penable     (penable),
    .pready      (pready),
    .frame_start (frame_start),
    .busy        (u_apb_regs.busy),
    .src_rd_en   (src_rd_en),
    .edge_we     (edge_we),
    .edge_addr   (edge_addr)
);

//--- dv/sobel_tb.sv
`timescale 1ns/1ps

module sobel_tb;

    import sobel_pkg::*;

    localparam int W           = 16;
    localparam int H           = 12;
    localparam int AW          = 8;
    localparam int PIXELS      = W * H;
    localparam int NUM_TESTS   = 10;
    localparam int CYCLE_LIMIT = 2000 * NUM_TESTS + 500;

    typedef enum int {
        PAT_FLAT,
        PAT_VSTEP,
        PAT_HSTEP,
        PAT_DIAG,
        PAT_RANDOM,
        PAT_KEEP
    } pattern_e;

    //////////////////////////////////////////////////
    // Test table
    //////////////////////////////////////////////////

    // Expected count of -1 takes the reference model count
    pattern_e tbl_pattern [NUM_TESTS] = '{PAT_FLAT, PAT_VSTEP, PAT_VSTEP, PAT_HSTEP,
                                          PAT_HSTEP, PAT_DIAG, PAT_DIAG, PAT_DIAG,
                                          PAT_RANDOM, PAT_KEEP};
    int tbl_thresh [NUM_TESTS] = '{3000, 1000, 2400, 1000, 1000, 200, 2000, 2000, 1500, 1500};
    int tbl_margin [NUM_TESTS] = '{0, 0, 0, 0, 3, 0, 0, 2, 0, 0};
    int tbl_count  [NUM_TESTS] = '{0, 20, 0, 28, 20, 37, 19, 15, -1, -1};

    logic          clk;
    logic          rst_n;
    logic          psel;
    logic          penable;
    logic          pwrite;
    apb_addr_t     paddr;
    apb_data_t     pwdata;
    apb_data_t     prdata;
    logic          pready;
    logic          pslverr;
    logic          src_rd_en;
    logic [AW-1:0] src_addr;
    rgb_t          src_data;
    logic          edge_we;
    logic [AW-1:0] edge_addr;
    logic          edge_bit;

    rgb_t          src_mem [PIXELS];
    logic [AW-1:0] rd_addr_q;
    logic          exp_edge [PIXELS];
    logic          got_edge [PIXELS];
    int            wr_hits [PIXELS];
    int            errors = 0;
    int            tests_run = 0;
    int            tests_failed = 0;
    int            cycles = 0;

    sobel_top #(
        .IMG_WIDTH  (W),
        .IMG_HEIGHT (H),
        .ADDR_W     (AW)
    ) dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .src_rd_en (src_rd_en),
        .src_addr  (src_addr),
        .src_data  (src_data),
        .edge_we   (edge_we),
        .edge_addr (edge_addr),
        .edge_bit  (edge_bit)
    );

    always #2 clk = ~clk;

    always @(posedge clk) cycles <= cycles + 1;

    // Source memory with data valid in the cycle after the read
    always @(negedge clk) begin
        src_data <= src_mem[rd_addr_q];
        if (src_rd_en) begin
            rd_addr_q <= src_addr;
        end
    end

    // Edge memory capture
    always @(negedge clk) begin
        if (rst_n && edge_we) begin
            if (edge_addr >= PIXELS) begin
                report_mismatch($sformatf("edge write to address %0d outside the frame",
                                          edge_addr));
            end else begin
                wr_hits[edge_addr]  = wr_hits[edge_addr] + 1;
                got_edge[edge_addr] = edge_bit;
            end
        end
    end

    initial begin : watchdog
        wait (cycles >= CYCLE_LIMIT);
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic report_mismatch(input string msg);
        errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    task automatic close_test(input string name, input int errors_before);
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
        end
        $display("%s: %s", name, (errors == errors_before) ? "ok" : "failed");
    endtask

    //////////////////////////////////////////////////
    // APB access
    //////////////////////////////////////////////////

    task automatic apb_transfer(input logic write, input apb_addr_t addr,
                                input apb_data_t wdata, input logic expect_err,
                                output apb_data_t rdata);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        rdata = prdata;
        if (pready !== 1'b1) begin
            report_mismatch($sformatf("pready %b in access phase at 0x%02h, expected 1",
                                      pready, addr));
        end
        if (pslverr !== expect_err) begin
            report_mismatch($sformatf("pslverr %b at 0x%02h, expected %b",
                                      pslverr, addr, expect_err));
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic reg_write(input apb_addr_t addr, input apb_data_t data,
                             input logic expect_err);
        apb_data_t unused;
        apb_transfer(1'b1, addr, data, expect_err, unused);
    endtask

    task automatic reg_read(input apb_addr_t addr, output apb_data_t data);
        apb_transfer(1'b0, addr, '0, 1'b0, data);
    endtask

    task automatic reg_check(input apb_addr_t addr, input apb_data_t expected);
        apb_data_t rd;
        reg_read(addr, rd);
        if (rd !== expected) begin
            report_mismatch($sformatf("register 0x%02h reads %0d, expected %0d",
                                      addr, rd, expected));
        end
    endtask

    //////////////////////////////////////////////////
    // Images and reference model
    //////////////////////////////////////////////////

    task automatic load_image(input pattern_e pat);
        for (int y = 0; y < H; y++) begin
            for (int x = 0; x < W; x++) begin
                case (pat)
                    PAT_FLAT:   src_mem[y*W+x] = 12'h888;
                    PAT_VSTEP:  src_mem[y*W+x] = (x >= W/2) ? 12'hFFF : 12'h000;
                    PAT_HSTEP:  src_mem[y*W+x] = (y >= H/2) ? 12'hFFF : 12'h000;
                    PAT_DIAG:   src_mem[y*W+x] = (x >= y) ? 12'hFFF : 12'h000;
                    PAT_RANDOM: src_mem[y*W+x] = 12'($urandom);
                    default:    src_mem[y*W+x] = src_mem[y*W+x];
                endcase
            end
        end
    endtask

    function automatic int gray(input int x, input int y);
        int r;
        int g;
        int b;
        r = src_mem[y*W+x][11:8];
        g = src_mem[y*W+x][7:4];
        b = src_mem[y*W+x][3:0];
        return r / 4 + g / 2 + g / 8 + b / 8;
    endfunction

    task automatic build_reference(input int thr, input int margin, output int count);
        int gx;
        int gy;
        int mag;
        bit masked;
        count = 0;
        for (int i = 0; i < PIXELS; i++) begin
            exp_edge[i] = 1'b0;
        end
        for (int y = 1; y < H - 1; y++) begin
            for (int x = 1; x < W - 1; x++) begin
                gx = gray(x-1, y-1) + 2 * gray(x-1, y) + gray(x-1, y+1)
                   - gray(x+1, y-1) - 2 * gray(x+1, y) - gray(x+1, y+1);
                gy = gray(x-1, y-1) + 2 * gray(x, y-1) + gray(x+1, y-1)
                   - gray(x-1, y+1) - 2 * gray(x, y+1) - gray(x+1, y+1);
                mag = gx * gx + gy * gy;
                masked = (x < margin) || (x > W - 1 - margin)
                      || (y < margin) || (y > H - 1 - margin);
                exp_edge[y*W+x] = (mag > thr) && !masked;
                if (exp_edge[y*W+x]) begin
                    count++;
                end
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic check_edge_map(input int t);
        bit interior;
        for (int i = 0; i < PIXELS; i++) begin
            interior = (i % W > 0) && (i % W < W - 1) && (i / W > 0) && (i / W < H - 1);
            if (interior && wr_hits[i] != 1) begin
                report_mismatch($sformatf("test %0d pixel (%0d,%0d) written %0d times",
                                          t, i % W, i / W, wr_hits[i]));
            end else if (!interior && wr_hits[i] != 0) begin
                report_mismatch($sformatf("test %0d border pixel (%0d,%0d) written",
                                          t, i % W, i / W));
            end else if (interior && got_edge[i] !== exp_edge[i]) begin
                report_mismatch($sformatf("test %0d pixel (%0d,%0d) edge %b, expected %b",
                                          t, i % W, i / W, got_edge[i], exp_edge[i]));
            end
        end
    endtask

    task automatic run_frame(input int t);
        int        model_count;
        int        exp_count;
        int        errors_before;
        apb_data_t status;
        errors_before = errors;
        load_image(tbl_pattern[t]);
        build_reference(tbl_thresh[t], tbl_margin[t], model_count);
        exp_count = (tbl_count[t] < 0) ? model_count : tbl_count[t];
        if (model_count != exp_count) begin
            report_mismatch($sformatf("test %0d model count %0d, table count %0d",
                                      t, model_count, exp_count));
        end
        for (int i = 0; i < PIXELS; i++) begin
            wr_hits[i]  = 0;
            got_edge[i] = 1'b0;
        end
        reg_write(REG_THRESH, tbl_thresh[t], 1'b0);
        reg_write(REG_MARGIN, tbl_margin[t], 1'b0);
        reg_write(REG_CTRL, 32'd1, 1'b0);
        // Threshold is locked while the frame runs
        reg_write(REG_THRESH, 32'd77, 1'b1);
        reg_check(REG_THRESH, tbl_thresh[t]);
        reg_check(REG_STATUS, 32'd1);
        do begin
            reg_read(REG_STATUS, status);
        end while (status[1] !== 1'b1);
        if (status !== 32'd2) begin
            report_mismatch($sformatf("test %0d STATUS %0d at end of frame", t, status));
        end
        reg_check(REG_EDGE_COUNT, exp_count);
        check_edge_map(t);
        close_test($sformatf("test %0d %s thresh %0d margin %0d edges %0d", t,
                             tbl_pattern[t].name(), tbl_thresh[t], tbl_margin[t],
                             exp_count), errors_before);
    endtask

    initial begin
        int        errors_before;
        apb_data_t unmapped_rd;
        void'($urandom(32'h7b27));
        clk       = 1'b0;
        rst_n     = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        src_data  = '0;
        rd_addr_q = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Reset values and read back
        errors_before = errors;
        reg_check(REG_THRESH, 32'd3000);
        reg_check(REG_MARGIN, 32'd0);
        reg_check(REG_STATUS, 32'd0);
        reg_check(REG_EDGE_COUNT, 32'd0);
        reg_check(REG_CTRL, 32'd0);
        reg_write(REG_THRESH, 32'd1234, 1'b0);
        reg_check(REG_THRESH, 32'd1234);
        reg_write(REG_MARGIN, 32'd5, 1'b0);
        reg_check(REG_MARGIN, 32'd5);
        close_test("register reset and read back", errors_before);

        // Unmapped addresses
        errors_before = errors;
        reg_write(8'h14, 32'd1, 1'b1);
        reg_write(8'h40, 32'd1, 1'b1);
        apb_transfer(1'b0, 8'h20, '0, 1'b1, unmapped_rd);
        reg_check(REG_STATUS, 32'd0);
        close_test("unmapped address errors", errors_before);

        for (int t = 0; t < NUM_TESTS; t++) begin
            run_frame(t);
        end

        if (dut.u_sva.fail_count != 0) begin
            $display("Protocol checker saw %0d assertion failures", dut.u_sva.fail_count);
            errors += dut.u_sva.fail_count;
        end
        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- compile.f
design/sobel_pkg.sv
design/sobel_apb_regs.sv
design/sobel_window_fetch.sv
design/sobel_gradient.sv
design/sobel_edge_writer.sv
design/sobel_top.sv
dv/sobel_sva.sv
dv/sobel_tb.sv

//--- Bender.yml
package:
  name: sobel_edge

sources:
  - design/sobel_pkg.sv
  - design/sobel_apb_regs.sv
  - design/sobel_window_fetch.sv
  - design/sobel_gradient.sv
  - design/sobel_edge_writer.sv
  - design/sobel_top.sv
  - target: test
    files:
      - dv/sobel_sva.sv
      - dv/sobel_tb.sv
